//--- run_sim.sh
#!/bin/sh
# build and run the sorting accelerator testbench with Verilator
set -e
cd "$(dirname "$0")"
mkdir -p build

verilator --binary --timing --assert \
    -f sort_accel_top.f \
    --top-module sort_accel_tb \
    -Mdir build/obj

./build/obj/Vsort_accel_tb | tee build/sim.log

if grep -q "^Finished with no errors$" build/sim.log; then
    exit 0
fi
exit 1

//--- sort_accel_top.f
+incdir+source
source/sort_pkg.sv
source/sort_comparator.sv
source/batcher_sorter_4.sv
source/batcher_sorter_8.sv
source/sort_apb_frontend.sv
source/sort_result_buffer.sv
source/sort_accel_top.sv
verification/sort_accel_tb.sv

//--- source/batcher_sorter_4.sv
/*
 * batcher_sorter_4
 * three-stage pipelined odd-even merge sorter for four words
 */
`timescale 1ns/1ps
`default_nettype none

module batcher_sorter_4 (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 signed_mode,
    input  sort_pkg::sort_word_u data_in  [4],
    output sort_pkg::sort_word_u data_out [4]
);

    sort_pkg::sort_word_u stage_1 [4];
    sort_pkg::sort_word_u stage_2 [4];
    // outer lanes skip the last stage
    sort_pkg::sort_word_u low_q;
    sort_pkg::sort_word_u high_q;
    // mode of the vector in stage 1 and stage 2
    logic [1:0] mode_q;

    always_ff @(posedge clock) begin
        if (!reset) begin
            mode_q <= '0;
            low_q  <= '0;
            high_q <= '0;
        end else begin
            mode_q <= {mode_q[0], signed_mode};
            low_q  <= stage_2[0];
            high_q <= stage_2[3];
        end
    end

    // stage 1, sort pairs (0,1) and (2,3)
    for (genvar i = 0; i < 2; i++) begin : g_stage_1
        sort_comparator u_cmp (
            .clock       (clock),
            .reset       (reset),
            .signed_mode (signed_mode),
            .data_in     (data_in[2*i:2*i+1]),
            .data_out    (stage_1[2*i:2*i+1])
        );
    end

    // stage 2, merge across pairs (0,2) and (1,3)
    for (genvar i = 0; i < 2; i++) begin : g_stage_2
        sort_pkg::sort_word_u pair_in  [2];
        sort_pkg::sort_word_u pair_out [2];
        assign pair_in[0]    = stage_1[i];
        assign pair_in[1]    = stage_1[i+2];
        assign stage_2[i]    = pair_out[0];
        assign stage_2[i+2]  = pair_out[1];
        sort_comparator u_cmp (
            .clock       (clock),
            .reset       (reset),
            .signed_mode (mode_q[0]),
            .data_in     (pair_in),
            .data_out    (pair_out)
        );
    end

    // stage 3, fix the middle pair
    sort_comparator u_cmp_mid (
        .clock       (clock),
        .reset       (reset),
        .signed_mode (mode_q[1]),
        .data_in     (stage_2[1:2]),
        .data_out    (data_out[1:2])
    );

    assign data_out[0] = low_q;
    assign data_out[3] = high_q;

endmodule

`default_nettype wire

//--- source/batcher_sorter_8.sv
/*
 * batcher_sorter_8
 * six-stage eight-word odd-even merge sorter, one new vector per cycle
 * valid and signed mode travel alongside in delay lines
 */
`timescale 1ns/1ps
`default_nettype none
`include "sort_consts.svh"

module batcher_sorter_8 (
    input  logic                   clock,
    input  logic                   reset,
    input  sort_pkg::sort_job_t    job,
    output sort_pkg::sort_vector_t sorted,
    output logic                   sorted_valid
);

    sort_pkg::sort_word_u stage_1 [8];
    sort_pkg::sort_word_u stage_2 [8];
    sort_pkg::sort_word_u stage_3 [8];
    sort_pkg::sort_word_u stage_4 [8];
    // bypass registers for lanes without a comparator
    sort_pkg::sort_word_u hold_3 [4];
    sort_pkg::sort_word_u hold_4 [2];

    // entry k belongs to the vector that entered k+1 cycles ago
    logic [`SORT_LATENCY-1:0] valid_delay;
    logic [`SORT_LATENCY-1:0] signed_delay;

    // ascending check under one view, used by the output check only
    function automatic logic is_ordered(sort_pkg::sort_vector_t v, logic signed_mode);
        logic ok;
        ok = 1'b1;
        for (int i = 0; i < `SORT_LANES - 1; i++) begin
            if (signed_mode ? (v[i].signed_view > v[i+1].signed_view)
                            : (v[i].unsigned_view > v[i+1].unsigned_view)) begin
                ok = 1'b0;
            end
        end
        return ok;
    endfunction

    always_ff @(posedge clock) begin
        if (!reset) begin
            valid_delay  <= '0;
            signed_delay <= '0;
        end else begin
            valid_delay  <= {valid_delay[`SORT_LATENCY-2:0], job.valid};
            signed_delay <= {signed_delay[`SORT_LATENCY-2:0], job.mode.signed_mode};
        end
    end

    assign sorted_valid = valid_delay[`SORT_LATENCY-1];

    //////////////////////////////////////////////////////////////////////
    // stages 1 to 3, each half sorted on its own
    for (genvar h = 0; h < 2; h++) begin : g_half
        sort_pkg::sort_word_u half_in  [4];
        sort_pkg::sort_word_u half_out [4];
        for (genvar j = 0; j < 4; j++) begin : g_lane
            assign half_in[j]       = job.vector[4*h+j];
            assign stage_1[4*h+j]   = half_out[j];
        end
        batcher_sorter_4 u_half (
            .clock       (clock),
            .reset       (reset),
            .signed_mode (job.mode.signed_mode),
            .data_in     (half_in),
            .data_out    (half_out)
        );
    end

    //////////////////////////////////////////////////////////////////////
    // stage 4, lane i against lane i+4
    for (genvar i = 0; i < 4; i++) begin : g_merge_a
        sort_pkg::sort_word_u pair_in  [2];
        sort_pkg::sort_word_u pair_out [2];
        assign pair_in[0]   = stage_1[i];
        assign pair_in[1]   = stage_1[i+4];
        assign stage_2[i]   = pair_out[0];
        assign stage_2[i+4] = pair_out[1];
        sort_comparator u_cmp (
            .clock       (clock),
            .reset       (reset),
            .signed_mode (signed_delay[2]),
            .data_in     (pair_in),
            .data_out    (pair_out)
        );
    end

    //////////////////////////////////////////////////////////////////////
    // stage 5, (2,4) and (3,5), outer lanes held
    for (genvar i = 0; i < 2; i++) begin : g_merge_b
        sort_pkg::sort_word_u pair_in  [2];
        sort_pkg::sort_word_u pair_out [2];
        assign pair_in[0]   = stage_2[i+2];
        assign pair_in[1]   = stage_2[i+4];
        assign stage_3[i+2] = pair_out[0];
        assign stage_3[i+4] = pair_out[1];
        sort_comparator u_cmp (
            .clock       (clock),
            .reset       (reset),
            .signed_mode (signed_delay[3]),
            .data_in     (pair_in),
            .data_out    (pair_out)
        );
    end

    assign stage_3[0] = hold_3[0];
    assign stage_3[1] = hold_3[1];
    assign stage_3[6] = hold_3[2];
    assign stage_3[7] = hold_3[3];

    //////////////////////////////////////////////////////////////////////
    // stage 6, neighbours (1,2) (3,4) (5,6), ends held
    for (genvar i = 0; i < 3; i++) begin : g_merge_c
        sort_comparator u_cmp (
            .clock       (clock),
            .reset       (reset),
            .signed_mode (signed_delay[4]),
            .data_in     (stage_3[2*i+1:2*i+2]),
            .data_out    (stage_4[2*i+1:2*i+2])
        );
    end

    assign stage_4[0] = hold_4[0];
    assign stage_4[7] = hold_4[1];

    always_ff @(posedge clock) begin
        if (!reset) begin
            hold_3 <= '{default: '0};
            hold_4 <= '{default: '0};
        end else begin
            hold_3[0] <= stage_2[0];
            hold_3[1] <= stage_2[1];
            hold_3[2] <= stage_2[6];
            hold_3[3] <= stage_2[7];
            hold_4[0] <= stage_3[0];
            hold_4[1] <= stage_3[7];
        end
    end

    for (genvar i = 0; i < `SORT_LANES; i++) begin : g_out
        assign sorted[i] = stage_4[i];
    end

    // fixed latency, and the result is ascending under its own mode
    assert property (@(posedge clock) disable iff (!reset)
        sorted_valid == $past(job.valid, `SORT_LATENCY));
    assert property (@(posedge clock) disable iff (!reset)
        sorted_valid |-> is_ordered(sorted, signed_delay[`SORT_LATENCY-1]));

endmodule

`default_nettype wire

//--- source/sort_accel_top.sv
/*
 * sort_accel_top
 * apb sorting accelerator: front end, merge network, result buffer
 */
`timescale 1ns/1ps
`default_nettype none

module sort_accel_top (
    input  logic               clock,
    input  logic               reset,
    input  sort_pkg::apb_req_t apb_req,
    output sort_pkg::apb_rsp_t apb_rsp
);

    sort_pkg::sort_job_t    job;
    sort_pkg::sort_mode_t   mode;
    sort_pkg::sort_vector_t sorted;
    logic                   sorted_valid;
    sort_pkg::sort_status_t status;
    sort_pkg::sort_word_u   result_word;
    logic [2:0]             result_index;

    // input side
    sort_apb_frontend u_frontend (
        .clock        (clock),
        .reset        (reset),
        .apb_req      (apb_req),
        .apb_rsp      (apb_rsp),
        .status       (status),
        .result_word  (result_word),
        .result_index (result_index),
        .job          (job),
        .mode         (mode)
    );

    // merge network
    batcher_sorter_8 u_network (
        .clock        (clock),
        .reset        (reset),
        .job          (job),
        .sorted       (sorted),
        .sorted_valid (sorted_valid)
    );

    // output side
    sort_result_buffer u_result (
        .clock        (clock),
        .reset        (reset),
        .start        (job.valid),
        .mode         (mode),
        .sorted       (sorted),
        .sorted_valid (sorted_valid),
        .result_index (result_index),
        .result_word  (result_word),
        .status       (status)
    );

endmodule

`default_nettype wire

//--- source/sort_apb_frontend.sv
/*
 * sort_apb_frontend
 * apb slave of the accelerator: load buffer, control, job launch, read mux
 */
`timescale 1ns/1ps
`default_nettype none
`include "sort_consts.svh"

module sort_apb_frontend (
    input  logic                   clock,
    input  logic                   reset,
    input  sort_pkg::apb_req_t     apb_req,
    output sort_pkg::apb_rsp_t     apb_rsp,
    input  sort_pkg::sort_status_t status,
    input  sort_pkg::sort_word_u   result_word,
    output logic [2:0]             result_index,
    output sort_pkg::sort_job_t    job,
    output sort_pkg::sort_mode_t   mode
);

    logic                   access;
    logic                   aligned;
    logic                   hit_data;
    logic                   hit_ctrl;
    logic                   hit_status;
    logic                   hit_result;
    logic                   load_write;
    logic                   start_req;
    logic                   start_ok;
    logic                   launch_q;
    sort_pkg::sort_mode_t   wr_mode;
    sort_pkg::sort_mode_t   mode_q;
    sort_pkg::sort_vector_t load_q;

    // access phase, always one cycle
    assign access = apb_req.psel && apb_req.penable;

    // slot blocks are 32 bytes, word aligned
    assign aligned    = apb_req.paddr[1:0] == 2'b00;
    assign hit_data   = aligned && {apb_req.paddr[7:5], 5'b0} == `SORT_ADDR_DATA;
    assign hit_result = aligned && {apb_req.paddr[7:5], 5'b0} == `SORT_ADDR_RESULT;
    assign hit_ctrl   = apb_req.paddr == `SORT_ADDR_CTRL;
    assign hit_status = apb_req.paddr == `SORT_ADDR_STATUS;

    // slot number for both load and result blocks
    assign result_index = apb_req.paddr[4:2];

    assign load_write = access && apb_req.pwrite && hit_data;
    assign start_req  = access && apb_req.pwrite && hit_ctrl
                        && apb_req.pwdata[`SORT_CTRL_START];
    // one job at a time
    assign start_ok   = start_req && !status.busy;

    assign wr_mode = '{signed_mode: apb_req.pwdata[`SORT_CTRL_SIGNED],
                       descending:  apb_req.pwdata[`SORT_CTRL_DESC]};

    //////////////////////////////////////////////////////////////////////
    // load buffer, mode latch, launch pulse
    always_ff @(posedge clock) begin
        if (!reset) begin
            load_q   <= '0;
            mode_q   <= '0;
            launch_q <= 1'b0;
        end else begin
            launch_q <= start_ok;
            if (load_write) begin
                load_q[result_index] <= apb_req.pwdata;
            end
            if (start_ok) begin
                mode_q <= wr_mode;
            end
        end
    end

    // network samples the buffer in the launch cycle, later writes are safe
    assign job  = '{valid: launch_q, mode: mode_q, vector: load_q};
    assign mode = mode_q;

    //////////////////////////////////////////////////////////////////////
    // read mux and error response
    always_comb begin
        apb_rsp        = '0;
        apb_rsp.pready = 1'b1;
        if (access && apb_req.pwrite) begin
            // only load slots and control take writes
            apb_rsp.pslverr = !(hit_data || hit_ctrl) || (start_req && status.busy);
        end else if (access) begin
            if (hit_data) begin
                // load slots are write only
                apb_rsp.pslverr = 1'b1;
            end else if (hit_ctrl) begin
                apb_rsp.prdata[`SORT_CTRL_SIGNED] = mode_q.signed_mode;
                apb_rsp.prdata[`SORT_CTRL_DESC]   = mode_q.descending;
            end else if (hit_status) begin
                apb_rsp.prdata = `SORT_DATA_WIDTH'(status);
            end else if (hit_result) begin
                apb_rsp.prdata = result_word.unsigned_view;
            end
        end
    end

    // zero wait states
    assert property (@(posedge clock) apb_rsp.pready);
    // launch only follows a start seen while idle
    assert property (@(posedge clock) disable iff (!reset)
        launch_q |-> !$past(status.busy));

endmodule

`default_nettype wire

//--- source/sort_comparator.sv
/*
 * sort_comparator
 * registered compare-exchange, the smaller word lands in element 0
 */
`timescale 1ns/1ps
`default_nettype none

module sort_comparator (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 signed_mode,
    input  sort_pkg::sort_word_u data_in  [2],
    output sort_pkg::sort_word_u data_out [2]
);

    logic swap;

    // same bits, view picked by mode
    always_comb begin
        if (signed_mode) begin
            swap = data_in[0].signed_view > data_in[1].signed_view;
        end else begin
            swap = data_in[0].unsigned_view > data_in[1].unsigned_view;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            data_out[0] <= '0;
            data_out[1] <= '0;
        end else begin
            data_out[0] <= swap ? data_in[1] : data_in[0];
            data_out[1] <= swap ? data_in[0] : data_in[1];
        end
    end

    // pair leaving the register is ordered under the mode it was compared with
    assert property (@(posedge clock) disable iff (!reset)
        $past(signed_mode) ? (data_out[0].signed_view <= data_out[1].signed_view)
                           : (data_out[0].unsigned_view <= data_out[1].unsigned_view));

endmodule

`default_nettype wire

//--- source/sort_consts.svh
/*
 * sorting accelerator constants
 * word width, lane count, network latency and the apb register map
 */
`ifndef SORT_CONSTS_SVH
`define SORT_CONSTS_SVH

// datapath shape
`define SORT_DATA_WIDTH 32
`define SORT_LANES 8
// cycles from job valid to sorted valid
`define SORT_LATENCY 6

// register map, byte addresses
`define SORT_ADDR_WIDTH 8
`define SORT_ADDR_DATA 8'h00
`define SORT_ADDR_CTRL 8'h20
`define SORT_ADDR_STATUS 8'h24
`define SORT_ADDR_RESULT 8'h40

// control word bits
`define SORT_CTRL_START 0
`define SORT_CTRL_SIGNED 1
`define SORT_CTRL_DESC 2

`endif

//--- source/sort_pkg.sv
/*
 * sort_pkg
 * shared types of the sorting accelerator: words, vectors, jobs, apb
 */
`default_nettype none
`include "sort_consts.svh"

package sort_pkg;

    // one word, read either as unsigned or as two's complement
    typedef union packed {
        logic        [`SORT_DATA_WIDTH-1:0] unsigned_view;
        logic signed [`SORT_DATA_WIDTH-1:0] signed_view;
    } sort_word_u;

    // lane 0 in the low bits
    typedef sort_word_u [`SORT_LANES-1:0] sort_vector_t;

    typedef struct packed {
        logic signed_mode;
        logic descending;
    } sort_mode_t;

    // one job into the network
    typedef struct packed {
        logic         valid;
        sort_mode_t   mode;
        sort_vector_t vector;
    } sort_job_t;

    // done above busy so busy sits in bit 0
    typedef struct packed {
        logic done;
        logic busy;
    } sort_status_t;

    typedef struct packed {
        logic                        psel;
        logic                        penable;
        logic                        pwrite;
        logic [`SORT_ADDR_WIDTH-1:0] paddr;
        logic [`SORT_DATA_WIDTH-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [`SORT_DATA_WIDTH-1:0] prdata;
        logic                        pready;
        logic                        pslverr;
    } apb_rsp_t;

endpackage

`default_nettype wire

//--- source/sort_result_buffer.sv
/*
 * sort_result_buffer
 * captures the sorted vector in the requested order, keeps busy and done
 */
`timescale 1ns/1ps
`default_nettype none
`include "sort_consts.svh"

module sort_result_buffer (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   start,
    input  sort_pkg::sort_mode_t   mode,
    input  sort_pkg::sort_vector_t sorted,
    input  logic                   sorted_valid,
    input  logic [2:0]             result_index,
    output sort_pkg::sort_word_u   result_word,
    output sort_pkg::sort_status_t status
);

    sort_pkg::sort_vector_t result_q;
    logic                   busy_q;
    logic                   done_q;

    always_ff @(posedge clock) begin
        if (!reset) begin
            result_q <= '0;
            busy_q   <= 1'b0;
            done_q   <= 1'b0;
        end else begin
            // a new job clears the previous done
            if (start) begin
                busy_q <= 1'b1;
                done_q <= 1'b0;
            end
            if (sorted_valid) begin
                busy_q <= 1'b0;
                done_q <= 1'b1;
                // network is ascending, flip lanes for descending
                for (int i = 0; i < `SORT_LANES; i++) begin
                    result_q[i] <= mode.descending ? sorted[`SORT_LANES-1-i] : sorted[i];
                end
            end
        end
    end

    // busy already visible in the launch cycle
    assign status      = '{done: done_q, busy: busy_q || start};
    assign result_word = result_q[result_index];

    // network output only ever belongs to a running job
    assert property (@(posedge clock) disable iff (!reset)
        sorted_valid |-> busy_q);

endmodule

`default_nettype wire

//--- verification/sort_accel_tb.sv
/*
 * sort_accel_tb
 * random and directed testbench for the apb sorting accelerator
 * drives apb transfers, checks results against a sort model
 */
`timescale 1ns/1ps
`default_nettype none
`include "sort_consts.svh"

module sort_accel_tb;

    // ~200 random jobs at ~60 cycles, plus margin for directed jobs
    localparam int random_jobs    = 200;
    localparam int cycles_per_job = 60;
    localparam int timeout_cycles = random_jobs * cycles_per_job + 8000;

    logic               clock;
    logic               reset;
    sort_pkg::apb_req_t apb_req;
    sort_pkg::apb_rsp_t apb_rsp;

    int errors;
    int checks;
    int tests;
    int test_start_errors;
    int cycle_count;

    // slots as written by software, and the vector the last start should give
    sort_pkg::sort_vector_t model_slots;
    sort_pkg::sort_vector_t expected_q;

    sort_pkg::sort_vector_t vec;
    sort_pkg::sort_mode_t   mode;
    sort_pkg::sort_status_t st;
    logic [31:0]            rd_data;
    logic [31:0]            rnd;
    logic                   err;

    sort_accel_top uut (
        .clock   (clock),
        .reset   (reset),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp)
    );

    always #2 clock = ~clock;

    // run limit
    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout, run did not end within %0d cycles", timeout_cycles);
            $display("Finished with errors");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // compare tasks
    task automatic check_word(string name, sort_pkg::sort_word_u exp, sort_pkg::sort_word_u act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_status(sort_pkg::sort_status_t exp, sort_pkg::sort_status_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %0t status expected %b got %b", $time, exp, act);
        end
    endtask

    task automatic check_error(logic exp, logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %0t pslverr expected %b got %b", $time, exp, act);
        end
    endtask

    task automatic check_ready(logic act);
        checks++;
        if (act !== 1'b1) begin
            errors++;
            $display("ERR %0t pready expected 1 got %b", $time, act);
        end
    endtask

    task automatic report_test(string name);
        $display("test %s %0d errors", name, errors - test_start_errors);
        test_start_errors = errors;
        tests++;
    endtask

    //////////////////////////////////////////////////////////////////////
    // apb driver, setup then access, sampled mid-cycle of the access phase
    task automatic apb_transfer(input logic write, input logic [7:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic slverr);
        @(posedge clock);
        apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
        @(posedge clock);
        apb_req.penable <= 1'b1;
        @(negedge clock);
        rdata  = apb_rsp.prdata;
        slverr = apb_rsp.pslverr;
        // zero wait states, every access completes here
        check_ready(apb_rsp.pready);
        @(posedge clock);
        apb_req <= '0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                             output logic slverr);
        logic [31:0] unused;
        apb_transfer(1'b1, addr, data, unused, slverr);
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic slverr);
        apb_transfer(1'b0, addr, 32'h0, data, slverr);
    endtask

    //////////////////////////////////////////////////////////////////////
    // reference model
    function automatic longint word_key(logic [31:0] w, logic signed_mode);
        if (signed_mode) begin
            return longint'($signed(w));
        end
        return longint'(w);
    endfunction

    function automatic sort_pkg::sort_vector_t model_sort(sort_pkg::sort_vector_t v,
                                                          sort_pkg::sort_mode_t m);
        sort_pkg::sort_vector_t r;
        sort_pkg::sort_word_u   t;
        r = v;
        // plain bubble sort, ascending
        for (int i = 0; i < `SORT_LANES; i++) begin
            for (int j = 0; j < `SORT_LANES - 1 - i; j++) begin
                if (word_key(r[j], m.signed_mode) > word_key(r[j+1], m.signed_mode)) begin
                    t      = r[j];
                    r[j]   = r[j+1];
                    r[j+1] = t;
                end
            end
        end
        if (m.descending) begin
            for (int i = 0; i < `SORT_LANES; i++) begin
                t = r[i];
                v[`SORT_LANES-1-i] = t;
            end
            r = v;
        end
        return r;
    endfunction

    // mostly random, some small values so duplicates show up
    function automatic sort_pkg::sort_vector_t random_vector();
        sort_pkg::sort_vector_t v;
        logic [31:0]            pick;
        for (int i = 0; i < `SORT_LANES; i++) begin
            pick = $urandom;
            v[i] = (pick[1:0] == 2'b00) ? ($urandom & 32'h8000_0003) : $urandom;
        end
        return v;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // job steps
    task automatic write_slots(sort_pkg::sort_vector_t v);
        logic slverr;
        for (int i = 0; i < `SORT_LANES; i++) begin
            apb_write(8'(`SORT_ADDR_DATA + 4 * i), v[i], slverr);
            check_error(1'b0, slverr);
            model_slots[i] = v[i];
        end
    endtask

    task automatic start_job(sort_pkg::sort_mode_t m);
        logic slverr;
        apb_write(`SORT_ADDR_CTRL, {29'b0, m.descending, m.signed_mode, 1'b1}, slverr);
        check_error(1'b0, slverr);
        expected_q = model_sort(model_slots, m);
    endtask

    task automatic wait_done();
        logic [31:0]            data;
        logic                   slverr;
        sort_pkg::sort_status_t s;
        s = '0;
        while (!s.done) begin
            apb_read(`SORT_ADDR_STATUS, data, slverr);
            check_error(1'b0, slverr);
            s = data[1:0];
        end
    endtask

    task automatic check_results();
        logic [31:0] data;
        logic        slverr;
        for (int i = 0; i < `SORT_LANES; i++) begin
            apb_read(8'(`SORT_ADDR_RESULT + 4 * i), data, slverr);
            check_error(1'b0, slverr);
            check_word($sformatf("result[%0d]", i), expected_q[i], data);
        end
    endtask

    task automatic run_job(sort_pkg::sort_vector_t v, sort_pkg::sort_mode_t m);
        write_slots(v);
        start_job(m);
        wait_done();
        check_results();
    endtask

    task automatic read_status(output sort_pkg::sort_status_t s);
        logic [31:0] data;
        logic        slverr;
        apb_read(`SORT_ADDR_STATUS, data, slverr);
        check_error(1'b0, slverr);
        s = data[1:0];
    endtask

    //////////////////////////////////////////////////////////////////////
    initial begin
        clock             = 1'b0;
        reset             = 1'b0;
        apb_req           = '0;
        errors            = 0;
        checks            = 0;
        tests             = 0;
        test_start_errors = 0;
        cycle_count       = 0;
        model_slots       = '0;
        expected_q        = '0;
        void'($urandom(32'hf256_2aef));
        repeat (8) @(posedge clock);
        reset <= 1'b1;

        // status sequence, from reset through two starts
        read_status(st);
        check_status('{done: 1'b0, busy: 1'b0}, st);
        apb_read(`SORT_ADDR_RESULT, rd_data, err);
        check_error(1'b0, err);
        check_word("result[0] after reset", '0, rd_data);
        write_slots(random_vector());
        start_job('{signed_mode: 1'b0, descending: 1'b0});
        read_status(st);
        check_status('{done: 1'b0, busy: 1'b1}, st);
        wait_done();
        read_status(st);
        check_status('{done: 1'b1, busy: 1'b0}, st);
        check_results();
        read_status(st);
        check_status('{done: 1'b1, busy: 1'b0}, st);
        start_job('{signed_mode: 1'b1, descending: 1'b1});
        read_status(st);
        check_status('{done: 1'b0, busy: 1'b1}, st);
        wait_done();
        check_results();
        report_test("status_sequence");

        // random words, random mode
        for (int n = 0; n < random_jobs; n++) begin
            rnd  = $urandom;
            mode = rnd[1:0];
            run_job(random_vector(), mode);
        end
        report_test("random_sorts");

        // negative words and words with the top bit set
        vec = {32'h9000_0001, 32'h0000_0005, 32'hc000_0000, 32'h0000_0001,
               32'h0000_0000, 32'hffff_ffff, 32'h7fff_ffff, 32'h8000_0000};
        run_job(vec, '{signed_mode: 1'b0, descending: 1'b0});
        run_job(vec, '{signed_mode: 1'b1, descending: 1'b0});
        report_test("signed_vs_unsigned");

        // rejected start while busy keeps the running job and its mode
        write_slots(random_vector());
        start_job('{signed_mode: 1'b0, descending: 1'b0});
        apb_write(`SORT_ADDR_CTRL, 32'h0000_0007, err);
        check_error(1'b1, err);
        wait_done();
        check_results();
        apb_write(8'(`SORT_ADDR_RESULT + 4), 32'hdead_beef, err);
        check_error(1'b1, err);
        apb_write(`SORT_ADDR_STATUS, 32'h0000_0003, err);
        check_error(1'b1, err);
        apb_write(8'h30, 32'h1234_5678, err);
        check_error(1'b1, err);
        apb_read(8'(`SORT_ADDR_DATA + 8), rd_data, err);
        check_error(1'b1, err);
        read_status(st);
        check_status('{done: 1'b1, busy: 1'b0}, st);
        check_results();
        // load slots untouched by the rejected writes
        start_job('{signed_mode: 1'b1, descending: 1'b0});
        wait_done();
        check_results();
        report_test("error_responses");

        // rewrite slots while the job runs
        write_slots(random_vector());
        start_job('{signed_mode: 1'b1, descending: 1'b0});
        write_slots(random_vector());
        wait_done();
        check_results();
        start_job('{signed_mode: 1'b0, descending: 1'b1});
        wait_done();
        check_results();
        report_test("load_independence");

        // equal words, extremes of both views, sorted and reversed input
        for (int k = 0; k < 4; k++) begin
            mode = k[1:0];
            run_job({`SORT_LANES{32'h1234_5678}}, mode);
            run_job({`SORT_LANES{32'h8000_0000}}, mode);
            run_job({32'h7fff_ffff, 32'h8000_0000, 32'hffff_ffff, 32'h0000_0000,
                     32'h7fff_ffff, 32'h8000_0000, 32'hffff_ffff, 32'h0000_0000}, mode);
            for (int i = 0; i < `SORT_LANES; i++) begin
                vec[i] = (32'(i) << 29) | 32'(i);
            end
            run_job(vec, mode);
            for (int i = 0; i < `SORT_LANES; i++) begin
                vec[i] = (32'(7 - i) << 29) | 32'(7 - i);
            end
            run_job(vec, mode);
        end
        report_test("extreme_values");

        $display("tests %0d checks %0d errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire
